// ==== hdl/fc_defines.svh ====
`ifndef FC_DEFINES_SVH
`define FC_DEFINES_SVH

// Datapath width, wraps on overflow
`define FC_DATA_W 16

// Output neurons
`define FC_NEURONS 4

// Input features per neuron
`define FC_DEPTH 16

// Feature index width, log2 of FC_DEPTH
`define FC_IDX_W 4

// Neuron index width, log2 of FC_NEURONS
`define FC_NEURON_W 2

`endif

// ==== hdl/fc_pkg.sv ====
`default_nettype none

`include "fc_defines.svh"

package fc_pkg;

	// One datapath word
	typedef logic [`FC_DATA_W-1:0] word_t;

	// Destination of a host write
	typedef enum logic [1:0]
	{
		tgt_feature,
		tgt_weight,
		tgt_bias
	} host_target_e;

	typedef enum logic [1:0]
	{
		st_idle,
		st_run,   // Clear, then one read per feature index
		st_drain, // Last accumulate
		st_load   // Result register load
	} seq_state_e;

endpackage

`default_nettype wire

// ==== hdl/fc_ctrl_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fc_defines.svh"

interface fc_ctrl_if;

	logic                 rd_en;  // Read all memories at rd_idx
	logic [`FC_IDX_W-1:0] rd_idx;
	logic                 clear;  // Zero the accumulators
	logic                 acc_en; // Add products this edge
	logic                 load;   // Register acc plus bias

	modport seq
	(
		output rd_en, rd_idx, clear, acc_en, load
	);

	modport store
	(
		input rd_en, rd_idx
	);

	modport mac
	(
		input clear, acc_en, load
	);

endinterface

`default_nettype wire

// ==== hdl/fc_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fc_defines.svh"

module fc_sequencer
(
	input  logic      clk,
	input  logic      reset,
	input  logic      start,
	output logic      busy,
	output logic      done,
	fc_ctrl_if.seq    ctrl
);

	localparam logic [`FC_IDX_W-1:0] last_idx = `FC_IDX_W'(`FC_DEPTH-1);

	fc_pkg::seq_state_e   state;
	logic [`FC_IDX_W-1:0] idx;
	logic                 rd_en;
	logic                 acc_en;
	logic                 clear;
	logic                 load;

	// Controls are registered so the datapath sees clean pulses
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state  <= fc_pkg::st_idle;
			idx    <= '0;
			rd_en  <= 1'b0;
			acc_en <= 1'b0;
			clear  <= 1'b0;
			load   <= 1'b0;
			done   <= 1'b0;
		end
		else
		begin
			clear  <= 1'b0;
			load   <= 1'b0;
			done   <= 1'b0;
			acc_en <= rd_en; // Covers the one-cycle memory read
			case (state)
				fc_pkg::st_idle:
				begin
					if (start)
					begin
						state <= fc_pkg::st_run;
						clear <= 1'b1;
						idx   <= '0;
					end
				end
				fc_pkg::st_run:
				begin
					rd_en <= 1'b1;
					if (rd_en)
					begin
						idx <= idx + 1'b1;
						if (idx == last_idx)
						begin
							rd_en <= 1'b0;
							state <= fc_pkg::st_drain;
						end
					end
				end
				fc_pkg::st_drain:
				begin
					load  <= 1'b1; // Final accumulate lands on this edge
					state <= fc_pkg::st_load;
				end
				fc_pkg::st_load:
				begin
					done  <= 1'b1; // Result registers update on this edge
					state <= fc_pkg::st_idle;
				end
				default:
				begin
					state <= fc_pkg::st_idle;
				end
			endcase
		end
	end

	assign busy = (state != fc_pkg::st_idle);

	assign ctrl.rd_en  = rd_en;
	assign ctrl.rd_idx = idx;
	assign ctrl.clear  = clear;
	assign ctrl.acc_en = acc_en;
	assign ctrl.load   = load;

endmodule

`default_nettype wire

// ==== hdl/fc_weight_store.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fc_defines.svh"

module fc_weight_store
(
	input  logic                                clk,
	input  logic                                host_wr,
	input  fc_pkg::host_target_e                host_target,
	input  logic [`FC_NEURON_W+`FC_IDX_W-1:0]   host_addr,
	input  logic [`FC_DATA_W-1:0]               host_data,
	fc_ctrl_if.store                            ctrl,
	output logic [`FC_DATA_W-1:0]               feature,
	output fc_pkg::word_t                       weights [`FC_NEURONS]
);

	logic [`FC_IDX_W-1:0]    wr_idx;
	logic [`FC_NEURON_W-1:0] wr_neuron;
	logic [`FC_IDX_W-1:0]    mem_addr;
	logic                    feat_we;

	fc_pkg::word_t feat_mem [`FC_DEPTH];

	assign wr_idx    = host_addr[`FC_IDX_W-1:0];
	assign wr_neuron = host_addr[`FC_NEURON_W+`FC_IDX_W-1:`FC_IDX_W];

	// One address per memory, shared by host and sequencer
	assign mem_addr = ctrl.rd_en ? ctrl.rd_idx : wr_idx;

	assign feat_we = host_wr && (host_target == fc_pkg::tgt_feature);

	always_ff @(posedge clk)
	begin
		if (feat_we)
		begin
			feat_mem[mem_addr] <= host_data;
		end
		if (ctrl.rd_en)
		begin
			feature <= feat_mem[mem_addr];
		end
	end

	for (genvar n = 0; n < `FC_NEURONS; n++)
	begin : g_wmem
		fc_pkg::word_t mem [`FC_DEPTH];
		logic          we;

		assign we = host_wr && (host_target == fc_pkg::tgt_weight) &&
			(wr_neuron == `FC_NEURON_W'(n));

		always_ff @(posedge clk)
		begin
			if (we)
			begin
				mem[mem_addr] <= host_data;
			end
			if (ctrl.rd_en)
			begin
				weights[n] <= mem[mem_addr]; // Same edge as the feature read
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/fc_mac_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fc_defines.svh"

module fc_mac_array
(
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic                                 bias_shift,
	input  logic [`FC_DATA_W-1:0]                bias_data,
	input  logic [`FC_DATA_W-1:0]                feature,
	input  fc_pkg::word_t                        weights [`FC_NEURONS],
	fc_ctrl_if.mac                               ctrl,
	output logic [`FC_NEURONS*`FC_DATA_W-1:0]    result
);

	fc_pkg::word_t relu_feat;
	fc_pkg::word_t prod  [`FC_NEURONS];
	fc_pkg::word_t acc   [`FC_NEURONS];
	fc_pkg::word_t bias  [`FC_NEURONS];
	fc_pkg::word_t res_q [`FC_NEURONS];

	// Negative features clamp to zero
	assign relu_feat = feature[`FC_DATA_W-1] ? '0 : feature;

	always_comb
	begin
		for (int n = 0; n < `FC_NEURONS; n++)
		begin
			prod[n] = relu_feat * weights[n]; // Low half only, wraps
		end
	end

	always_ff @(posedge clk)
	begin
		for (int n = 0; n < `FC_NEURONS; n++)
		begin
			if (ctrl.clear)
			begin
				acc[n] <= '0;
			end
			else if (ctrl.acc_en)
			begin
				acc[n] <= acc[n] + prod[n];
			end
		end
	end

	// New bias enters at the top neuron and moves down one per write
	always_ff @(posedge clk)
	begin
		if (bias_shift)
		begin
			for (int n = 0; n < `FC_NEURONS-1; n++)
			begin
				bias[n] <= bias[n+1];
			end
			bias[`FC_NEURONS-1] <= bias_data;
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int n = 0; n < `FC_NEURONS; n++)
			begin
				res_q[n] <= '0;
			end
		end
		else if (ctrl.load)
		begin
			for (int n = 0; n < `FC_NEURONS; n++)
			begin
				res_q[n] <= acc[n] + bias[n];
			end
		end
	end

	for (genvar n = 0; n < `FC_NEURONS; n++)
	begin : g_flat
		assign result[n*`FC_DATA_W +: `FC_DATA_W] = res_q[n]; // Neuron 0 lowest
	end

endmodule

`default_nettype wire

// ==== hdl/fc_layer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fc_defines.svh"

module fc_layer
(
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic                                 start,
	input  logic                                 host_wr,
	input  fc_pkg::host_target_e                 host_target,
	input  logic [`FC_NEURON_W+`FC_IDX_W-1:0]    host_addr,
	input  logic [`FC_DATA_W-1:0]                host_data,
	output logic                                 busy,
	output logic                                 done,
	output logic [`FC_NEURONS*`FC_DATA_W-1:0]    result
);

	logic [`FC_DATA_W-1:0] feature;
	fc_pkg::word_t         weights [`FC_NEURONS];
	logic                  bias_shift;

	fc_ctrl_if ctrl_i ();

	// Bias writes skip the store and go straight to the chain
	assign bias_shift = host_wr && (host_target == fc_pkg::tgt_bias);

	fc_sequencer seq_i
	(
		.clk   (clk),
		.reset (reset),
		.start (start),
		.busy  (busy),
		.done  (done),
		.ctrl  (ctrl_i.seq)
	);

	fc_weight_store store_i
	(
		.clk         (clk),
		.host_wr     (host_wr),
		.host_target (host_target),
		.host_addr   (host_addr),
		.host_data   (host_data),
		.ctrl        (ctrl_i.store),
		.feature     (feature),
		.weights     (weights)
	);

	fc_mac_array mac_i
	(
		.clk        (clk),
		.reset      (reset),
		.bias_shift (bias_shift),
		.bias_data  (host_data),
		.feature    (feature),
		.weights    (weights),
		.ctrl       (ctrl_i.mac),
		.result     (result)
	);

endmodule

`default_nettype wire

// ==== test/fc_layer_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fc_defines.svh"

module fc_layer_properties
(
	input logic clk,
	input logic reset,
	input logic start,
	input logic host_wr,
	input logic busy,
	input logic done
);

	localparam int latency = `FC_DEPTH + 3;

	done_single: assert property (@(posedge clk) disable iff (reset) done |=> !done)
		else $error("done stayed high for more than one cycle");

	// done rises on edge latency, so it is sampled high one edge later
	done_latency: assert property (@(posedge clk) disable iff (reset)
		(start && !busy) |-> ##(latency + 1) done)
		else $error("done did not follow an accepted start at the fixed latency");

	idle_in_reset: assert property (@(posedge clk) reset |-> !busy)
		else $error("busy high while reset is asserted");

	no_write_busy: assert property (@(posedge clk) disable iff (reset) host_wr |-> !busy)
		else $error("host write issued while busy");

endmodule

bind fc_layer fc_layer_properties props_i
(
	.clk     (clk),
	.reset   (reset),
	.start   (start),
	.host_wr (host_wr),
	.busy    (busy),
	.done    (done)
);

`default_nettype wire

// ==== test/fc_layer_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fc_defines.svh"

module fc_layer_tb;

	localparam int run_cycles  = `FC_DEPTH + 3;
	localparam int load_cycles = (`FC_NEURONS + 1) * `FC_DEPTH + `FC_NEURONS + 2;
	localparam int num_runs    = 44;
	localparam int max_cycles  = num_runs * (load_cycles + run_cycles + 4) + 3 * run_cycles + 100;

	logic                                 clk;
	logic                                 reset;
	logic                                 start;
	logic                                 host_wr;
	fc_pkg::host_target_e                 host_target;
	logic [`FC_NEURON_W+`FC_IDX_W-1:0]    host_addr;
	logic [`FC_DATA_W-1:0]                host_data;
	logic                                 busy;
	logic                                 done;
	logic [`FC_NEURONS*`FC_DATA_W-1:0]    result;

	// Model copies of everything the host wrote
	logic [`FC_DATA_W-1:0] feat_m [`FC_DEPTH];
	logic [`FC_DATA_W-1:0] wt_m   [`FC_NEURONS][`FC_DEPTH];
	logic [`FC_DATA_W-1:0] bias_m [`FC_NEURONS];

	logic [31:0] lcg_state;
	int          cycles = 0;
	int          checks = 0;
	int          value_errors = 0;
	int          other_errors = 0;

	fc_layer dut_i
	(
		.clk         (clk),
		.reset       (reset),
		.start       (start),
		.host_wr     (host_wr),
		.host_target (host_target),
		.host_addr   (host_addr),
		.host_data   (host_data),
		.busy        (busy),
		.done        (done),
		.result      (result)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > max_cycles)
		begin
			$display("Timeout, the run went past %0d cycles", max_cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	function automatic logic [`FC_DATA_W-1:0] rand_word();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31 -: `FC_DATA_W]; // Upper bits are the better ones
	endfunction

	function automatic int rand_below(input int limit);
		return int'(rand_word()) % limit;
	endfunction

	// Bias plus sum of relu(feature) * weight, wrapping
	function automatic logic [`FC_DATA_W-1:0] model_result(input int n);
		logic [`FC_DATA_W-1:0] acc;
		logic [`FC_DATA_W-1:0] f;
		acc = bias_m[n];
		for (int i = 0; i < `FC_DEPTH; i++)
		begin
			f = feat_m[i][`FC_DATA_W-1] ? '0 : feat_m[i];
			acc = acc + f * wt_m[n][i];
		end
		return acc;
	endfunction

	task automatic host_write(input fc_pkg::host_target_e tgt, input int n, input int i,
		input logic [`FC_DATA_W-1:0] data);
		@(posedge clk);
		host_wr     <= 1'b1;
		host_target <= tgt;
		host_addr   <= {`FC_NEURON_W'(n), `FC_IDX_W'(i)};
		host_data   <= data;
		case (tgt)
			fc_pkg::tgt_feature: feat_m[i] = data;
			fc_pkg::tgt_weight:  wt_m[n][i] = data;
			default:
			begin
				for (int k = 0; k < `FC_NEURONS - 1; k++)
				begin
					bias_m[k] = bias_m[k+1];
				end
				bias_m[`FC_NEURONS-1] = data; // Newest at the top neuron
			end
		endcase
	endtask

	task automatic end_writes();
		@(posedge clk);
		host_wr <= 1'b0;
	endtask

	// neg_every forces a negative feature at every such index, 0 for none
	task automatic load_random(input int neg_every);
		logic [`FC_DATA_W-1:0] d;
		for (int i = 0; i < `FC_DEPTH; i++)
		begin
			d = rand_word();
			if (neg_every > 0 && i % neg_every == 0)
			begin
				d[`FC_DATA_W-1] = 1'b1;
			end
			host_write(fc_pkg::tgt_feature, 0, i, d);
		end
		for (int n = 0; n < `FC_NEURONS; n++)
		begin
			for (int i = 0; i < `FC_DEPTH; i++)
			begin
				host_write(fc_pkg::tgt_weight, n, i, rand_word());
			end
		end
		for (int n = 0; n < `FC_NEURONS; n++)
		begin
			host_write(fc_pkg::tgt_bias, 0, 0, rand_word());
		end
		end_writes();
	endtask

	task automatic run_layer();
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		@(posedge clk);
		while (!done)
		begin
			checks++;
			assert (busy)
			else
			begin
				other_errors++;
				$display("busy was low during a run before done");
			end
			@(posedge clk);
		end
		checks++;
		assert (!busy)
		else
		begin
			other_errors++;
			$display("busy was still high while done was high");
		end
	endtask

	task automatic compare_word(input string name, input int n,
		input logic [`FC_DATA_W-1:0] expected, input logic [`FC_DATA_W-1:0] actual);
		checks++;
		assert (actual == expected)
		else
		begin
			value_errors++;
			$display("Error %s neuron %0d: expected %h, actual %h", name, n, expected, actual);
		end
	endtask

	task automatic check_results(input string name, input logic [`FC_NEURONS*`FC_DATA_W-1:0] vec);
		for (int n = 0; n < `FC_NEURONS; n++)
		begin
			compare_word(name, n, model_result(n), vec[n*`FC_DATA_W +: `FC_DATA_W]);
		end
	endtask

	initial
	begin
		logic [`FC_DATA_W-1:0]             bias_seq [`FC_NEURONS];
		logic [`FC_NEURONS*`FC_DATA_W-1:0] held;
		int                                done_count;
		int                                n_sel;
		int                                i_sel;
		reset       <= 1'b1;
		start       <= 1'b0;
		host_wr     <= 1'b0;
		host_target <= fc_pkg::tgt_feature;
		host_addr   <= '0;
		host_data   <= '0;
		lcg_state = 32'h81a0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		repeat (2) @(posedge clk);

		checks++;
		assert (!busy && !done)
		else
		begin
			other_errors++;
			$display("busy or done is not low after reset");
		end
		for (int n = 0; n < `FC_NEURONS; n++)
		begin
			compare_word("reset", n, '0, result[n*`FC_DATA_W +: `FC_DATA_W]);
		end

		load_random(3); // Every third feature negative
		run_layer();
		check_results("random_load", result);

		for (int n = 0; n < `FC_NEURONS; n++)
		begin
			bias_seq[n] = rand_word();
			host_write(fc_pkg::tgt_bias, 0, 0, bias_seq[n]);
		end
		for (int n = 0; n < `FC_NEURONS; n++)
		begin
			for (int i = 0; i < `FC_DEPTH; i++)
			begin
				host_write(fc_pkg::tgt_weight, n, i, '0);
			end
		end
		end_writes();
		run_layer();
		for (int n = 0; n < `FC_NEURONS; n++)
		begin
			compare_word("bias_order", n, bias_seq[n], result[n*`FC_DATA_W +: `FC_DATA_W]);
		end

		// Everything not rewritten here must stay as before
		repeat (6)
		begin
			n_sel = rand_below(`FC_NEURONS);
			i_sel = rand_below(`FC_DEPTH);
			host_write(fc_pkg::tgt_weight, n_sel, i_sel, rand_word());
		end
		repeat (3)
		begin
			i_sel = rand_below(`FC_DEPTH);
			host_write(fc_pkg::tgt_feature, 0, i_sel, rand_word());
		end
		end_writes();
		run_layer();
		check_results("partial_rewrite", result);

		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		repeat (4) @(posedge clk);
		start <= 1'b1; // Lands mid run
		@(posedge clk);
		start <= 1'b0;
		done_count = 0;
		held = '0;
		repeat (2 * run_cycles)
		begin
			@(posedge clk);
			if (done)
			begin
				done_count++;
				held = result;
			end
		end
		checks++;
		assert (done_count == 1)
		else
		begin
			other_errors++;
			$display("Start during busy was not ignored, %0d done pulses seen", done_count);
		end
		check_results("start_while_busy", held);

		for (int r = 0; r < 40; r++)
		begin
			load_random(0);
			run_layer();
			check_results($sformatf("back_to_back_%0d", r), result);
		end

		$display("Checks %0d, value errors %0d, other errors %0d",
			checks, value_errors, other_errors);
		if (value_errors + other_errors == 0)
		begin
			$display("TEST OK");
		end
		else
		begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+hdl
hdl/fc_pkg.sv
hdl/fc_ctrl_if.sv
hdl/fc_sequencer.sv
hdl/fc_weight_store.sv
hdl/fc_mac_array.sv
hdl/fc_layer.sv
test/fc_layer_properties.sv
test/fc_layer_tb.sv

// ==== Makefile ====
SRCS := $(wildcard hdl/*.sv hdl/*.svh test/*.sv)

.PHONY: run clean

run: obj_dir/Vfc_layer_tb
	./obj_dir/Vfc_layer_tb > sim.log 2>&1; cat sim.log
	@if grep -q "TEST FAILED" sim.log; then \
		echo "Simulation reported failure"; exit 1; \
	elif grep -q "TEST OK" sim.log; then \
		echo "Simulation passed"; \
	else \
		echo "Simulation ended without a verdict"; exit 1; \
	fi

obj_dir/Vfc_layer_tb: compile.f $(SRCS)
	verilator --binary --timing --assert --top-module fc_layer_tb -f compile.f

clean:
	rm -rf obj_dir sim.log
